// File: hdl/io_pkg.sv
package io_pkg;

	// bus and register data word.
	typedef logic [15:0] data_t;

	// wishbone word address.
	typedef logic [4:0] waddr_t;

	// register index inside one block.
	typedef logic [1:0] reg_idx_t;

	typedef enum logic [1:0]
	{
		BLK_NONE,
		BLK_IRQ,
		BLK_TIMER,
		BLK_GPIO
	} blk_sel_t;

	// one decoded register access, applied while valid is high.
	typedef struct packed
	{
		blk_sel_t blk;
		reg_idx_t idx;
		logic we;
		data_t wdata;
		logic valid;
	} reg_req_t;

	// block base addresses, four words per block.
	localparam waddr_t IRQ_BASE = 5'd0;
	localparam waddr_t TIMER_BASE = 5'd4;
	localparam waddr_t GPIO_BASE = 5'd8;

	localparam reg_idx_t IRQ_ENABLE = 2'd0;
	localparam reg_idx_t IRQ_PENDING = 2'd1;

	localparam reg_idx_t TMR_CONFIG = 2'd0;
	localparam reg_idx_t TMR_COUNTER = 2'd1;
	localparam reg_idx_t TMR_RELOAD = 2'd2;
	localparam reg_idx_t TMR_COMPARE = 2'd3;

	localparam reg_idx_t GPIO_DIR = 2'd0;
	localparam reg_idx_t GPIO_OUT = 2'd1;
	localparam reg_idx_t GPIO_IN = 2'd2;

	// sources are timer overflow, timer compare and gpio pin change.
	localparam int IRQ_NUM = 3;

endpackage

// File: hdl/wb_slave_port.sv
`timescale 1ns/1ps

module wb_slave_port
	import io_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic cyc,
	input logic stb,
	input logic we,
	input waddr_t adr,
	input data_t dat_w,
	output reg_req_t req,
	input logic ack
);

	logic busy;
	logic start;
	blk_sel_t dec_blk;
	reg_idx_t dec_idx;
	waddr_t blk_base;

	assign start = cyc && stb && !busy;

	// word address to block and register.
	assign blk_base = {adr[4:2], 2'b00};
	assign dec_idx = adr[1:0];

	always_comb
	begin
		dec_blk = BLK_NONE;
		case (blk_base)
			IRQ_BASE:
				if (dec_idx <= IRQ_PENDING)
					dec_blk = BLK_IRQ;
			TIMER_BASE:
				dec_blk = BLK_TIMER;
			GPIO_BASE:
				if (dec_idx <= GPIO_IN)
					dec_blk = BLK_GPIO;
			default:
				dec_blk = BLK_NONE;
		endcase
	end

	// one request in flight, busy until the read mux acknowledges it.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			req <= '0;
			busy <= 1'b0;
		end
		else
		begin
			req.valid <= 1'b0;
			if (start)
			begin
				req.blk <= dec_blk;
				req.idx <= dec_idx;
				req.we <= we;
				req.wdata <= dat_w;
				req.valid <= 1'b1;
				busy <= 1'b1;
			end
			else if (ack)
				busy <= 1'b0;
		end
	end

endmodule

// File: hdl/io_timer.sv
`timescale 1ns/1ps

module io_timer
	import io_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input reg_req_t req,
	output data_t rdata,
	output logic ovf_evt,
	output logic cmp_evt
);

	localparam data_t CNT_MAX = 16'hFFFF;

	logic tmr_en;
	data_t counter;
	data_t reload;
	data_t compare;
	logic wr;

	assign wr = req.valid && req.we && (req.blk == BLK_TIMER);

	// config, reload and compare.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			tmr_en <= 1'b0;
			reload <= '0;
			compare <= '0;
		end
		else if (wr)
		begin
			case (req.idx)
				TMR_CONFIG: tmr_en <= req.wdata[0];
				TMR_RELOAD: reload <= req.wdata;
				TMR_COMPARE: compare <= req.wdata;
				default: ;
			endcase
		end
	end

	// a bus write to the counter wins over counting.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			counter <= '0;
			ovf_evt <= 1'b0;
			cmp_evt <= 1'b0;
		end
		else
		begin
			ovf_evt <= 1'b0;
			cmp_evt <= tmr_en && (counter == compare);
			if (wr && (req.idx == TMR_COUNTER))
				counter <= req.wdata;
			else if (tmr_en)
			begin
				if (counter == CNT_MAX)
				begin
					counter <= reload;
					ovf_evt <= 1'b1;
				end
				else
					counter <= counter + 1'b1;
			end
		end
	end

	always_comb
	begin
		case (req.idx)
			TMR_CONFIG: rdata = {15'b0, tmr_en};
			TMR_COUNTER: rdata = counter;
			TMR_RELOAD: rdata = reload;
			default: rdata = compare;
		endcase
	end

endmodule

// File: hdl/io_gpio.sv
`timescale 1ns/1ps

module io_gpio
	import io_pkg::*;
#(
	parameter int GPIO_WIDTH = 8
)
(
	input logic clk,
	input logic arst_n,
	input reg_req_t req,
	output data_t rdata,
	input logic [GPIO_WIDTH-1:0] pin_in,
	output logic [GPIO_WIDTH-1:0] pin_out,
	output logic [GPIO_WIDTH-1:0] pin_oe,
	output logic chg_evt
);

	logic [GPIO_WIDTH-1:0] dir;
	logic [GPIO_WIDTH-1:0] out;
	logic [GPIO_WIDTH-1:0] in_meta;
	logic [GPIO_WIDTH-1:0] in_sync;
	logic wr;

	assign wr = req.valid && req.we && (req.blk == BLK_GPIO);

	// input register is read only.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			dir <= '0;
			out <= '0;
		end
		else if (wr)
		begin
			if (req.idx == GPIO_DIR)
				dir <= req.wdata[GPIO_WIDTH-1:0];
			else if (req.idx == GPIO_OUT)
				out <= req.wdata[GPIO_WIDTH-1:0];
		end
	end

	// two stage synchronizer, the event lines up with the new in_sync value.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			in_meta <= '0;
			in_sync <= '0;
			chg_evt <= 1'b0;
		end
		else
		begin
			in_meta <= pin_in;
			in_sync <= in_meta;
			chg_evt <= (in_meta != in_sync);
		end
	end

	assign pin_oe = dir;
	assign pin_out = out;

	always_comb
	begin
		case (req.idx)
			GPIO_DIR: rdata = data_t'(dir);
			GPIO_OUT: rdata = data_t'(out);
			GPIO_IN: rdata = data_t'(in_sync);
			default: rdata = '0;
		endcase
	end

endmodule

// File: hdl/irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl
	import io_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input reg_req_t req,
	output data_t rdata,
	input logic [IRQ_NUM-1:0] src_evt,
	output logic irq
);

	logic [IRQ_NUM-1:0] enable;
	logic [IRQ_NUM-1:0] pending;
	logic [IRQ_NUM-1:0] clr;
	logic wr;

	assign wr = req.valid && req.we && (req.blk == BLK_IRQ);
	assign clr = (wr && (req.idx == IRQ_PENDING)) ? req.wdata[IRQ_NUM-1:0] : '0;

	// write one to clear, a new event in the same cycle wins.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			enable <= '0;
			pending <= '0;
			irq <= 1'b0;
		end
		else
		begin
			if (wr && (req.idx == IRQ_ENABLE))
				enable <= req.wdata[IRQ_NUM-1:0];
			pending <= (pending & ~clr) | src_evt;
			irq <= |(pending & enable);
		end
	end

	always_comb
	begin
		case (req.idx)
			IRQ_ENABLE: rdata = data_t'(enable);
			IRQ_PENDING: rdata = data_t'(pending);
			default: rdata = '0;
		endcase
	end

endmodule

// File: hdl/wb_read_mux.sv
`timescale 1ns/1ps

module wb_read_mux
	import io_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input reg_req_t req,
	input data_t irq_rdata,
	input data_t tmr_rdata,
	input data_t gpio_rdata,
	output data_t dat_r,
	output logic ack
);

	data_t sel_rdata;

	always_comb
	begin
		case (req.blk)
			BLK_IRQ: sel_rdata = irq_rdata;
			BLK_TIMER: sel_rdata = tmr_rdata;
			BLK_GPIO: sel_rdata = gpio_rdata;
			default: sel_rdata = '0;
		endcase
	end

	// read data and ack leave together, one cycle after the request.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ack <= 1'b0;
			dat_r <= '0;
		end
		else
		begin
			ack <= req.valid;
			if (req.valid && !req.we)
				dat_r <= sel_rdata;
		end
	end

endmodule

// File: hdl/io_system.sv
`timescale 1ns/1ps

module io_system
	import io_pkg::*;
#(
	parameter int GPIO_WIDTH = 8
)
(
	input logic clk,
	input logic arst_n,
	input logic cyc,
	input logic stb,
	input logic we,
	input waddr_t adr,
	input data_t dat_w,
	output data_t dat_r,
	output logic ack,
	output logic irq,
	input logic [GPIO_WIDTH-1:0] pin_in,
	output logic [GPIO_WIDTH-1:0] pin_out,
	output logic [GPIO_WIDTH-1:0] pin_oe
);

	reg_req_t req;
	data_t irq_rdata;
	data_t tmr_rdata;
	data_t gpio_rdata;
	logic ovf_evt;
	logic cmp_evt;
	logic chg_evt;

	wb_slave_port i_wb_slave_port (
		.clk, .arst_n, .cyc, .stb, .we, .adr, .dat_w,
		.req, .ack
	);

	io_timer i_io_timer (
		.clk, .arst_n, .req,
		.rdata(tmr_rdata), .ovf_evt, .cmp_evt
	);

	io_gpio #(.GPIO_WIDTH(GPIO_WIDTH)) i_io_gpio (
		.clk, .arst_n, .req,
		.rdata(gpio_rdata), .pin_in, .pin_out, .pin_oe, .chg_evt
	);

	// source order is overflow, compare, pin change.
	irq_ctrl i_irq_ctrl (
		.clk, .arst_n, .req,
		.rdata(irq_rdata),
		.src_evt({chg_evt, cmp_evt, ovf_evt}),
		.irq
	);

	wb_read_mux i_wb_read_mux (
		.clk, .arst_n, .req,
		.irq_rdata, .tmr_rdata, .gpio_rdata,
		.dat_r, .ack
	);

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
#(
	parameter int HALF_PERIOD = 4
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
	end

	always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: bench/io_asserts.sv
`timescale 1ns/1ps

module io_asserts
(
	input logic clk,
	input logic arst_n,
	input logic cyc,
	input logic stb,
	input logic busy,
	input logic valid,
	input logic ack
);

	logic start;

	// a transfer starts when the port is idle and sees a strobe.
	assign start = cyc && stb && !busy;

	ack_single: assert property (@(posedge clk) disable iff (!arst_n) ack |=> !ack)
		else $error("ack was high for two cycles in a row");

	valid_from_idle: assert property (@(posedge clk) disable iff (!arst_n)
		valid |-> $past(start))
		else $error("request issued without an idle strobe");

	// fixed latency, the read mux answers one cycle after the request.
	ack_latency: assert property (@(posedge clk) disable iff (!arst_n) start |-> ##2 ack)
		else $error("ack did not follow two cycles after a new strobe");

endmodule

// File: bench/io_tb.sv
`timescale 1ns/1ps

module io_tb
	import io_pkg::*;
();

	localparam int GPIO_WIDTH = 8;

	localparam waddr_t A_IRQ_EN = IRQ_BASE;
	localparam waddr_t A_PEND = IRQ_BASE + 5'd1;
	localparam waddr_t A_CFG = TIMER_BASE;
	localparam waddr_t A_CNT = TIMER_BASE + 5'd1;
	localparam waddr_t A_RLD = TIMER_BASE + 5'd2;
	localparam waddr_t A_CMP = TIMER_BASE + 5'd3;
	localparam waddr_t A_DIR = GPIO_BASE;
	localparam waddr_t A_OUT = GPIO_BASE + 5'd1;
	localparam waddr_t A_IN = GPIO_BASE + 5'd2;

	// one queued check with lo equal to hi for an exact value.
	typedef struct packed
	{
		data_t lo;
		data_t hi;
		data_t act;
	} chk_t;

	logic clk;
	logic arst_n;
	logic cyc;
	logic stb;
	logic we;
	waddr_t adr;
	data_t dat_w;
	data_t dat_r;
	logic ack;
	logic irq;
	logic [GPIO_WIDTH-1:0] pin_in;
	logic [GPIO_WIDTH-1:0] pin_out;
	logic [GPIO_WIDTH-1:0] pin_oe;

	logic [IRQ_NUM-1:0] sh_irq_en;
	logic [IRQ_NUM-1:0] sh_pending;
	logic sh_tmr_en;
	data_t sh_counter;
	data_t sh_reload;
	data_t sh_compare;
	logic [GPIO_WIDTH-1:0] sh_dir;
	logic [GPIO_WIDTH-1:0] sh_out;
	logic [GPIO_WIDTH-1:0] sh_pin;

	integer seed;
	int cycle;
	int mismatch_count;
	int timeout_count;
	chk_t chk_q[$];
	string name_q[$];
	chk_t cur;
	string cur_name;

	tb_clock i_tb_clock (.clk);

	io_system #(.GPIO_WIDTH(GPIO_WIDTH)) i_io_system (
		.clk, .arst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
		.irq, .pin_in, .pin_out, .pin_oe
	);

	bind wb_slave_port io_asserts i_io_asserts (
		.clk(clk), .arst_n(arst_n), .cyc(cyc), .stb(stb),
		.busy(busy), .valid(req.valid), .ack(ack)
	);

	always @(posedge clk)
		cycle <= cycle + 1;

	// expected register contents as the register map defines them.
	function automatic data_t model_read(input waddr_t a);
		case (a)
			A_IRQ_EN: model_read = data_t'(sh_irq_en);
			A_PEND: model_read = data_t'(sh_pending);
			A_CFG: model_read = {15'b0, sh_tmr_en};
			A_CNT: model_read = sh_counter;
			A_RLD: model_read = sh_reload;
			A_CMP: model_read = sh_compare;
			A_DIR: model_read = data_t'(sh_dir);
			A_OUT: model_read = data_t'(sh_out);
			A_IN: model_read = data_t'(sh_pin);
			default: model_read = '0;
		endcase
	endfunction

	function automatic void model_write(input waddr_t a, input data_t d);
		case (a)
			A_IRQ_EN: sh_irq_en = d[IRQ_NUM-1:0];
			A_PEND: sh_pending = sh_pending & ~d[IRQ_NUM-1:0];
			A_CFG: sh_tmr_en = d[0];
			A_CNT: sh_counter = d;
			A_RLD: sh_reload = d;
			A_CMP: sh_compare = d;
			A_DIR: sh_dir = d[GPIO_WIDTH-1:0];
			A_OUT: sh_out = d[GPIO_WIDTH-1:0];
			default: ;
		endcase
	endfunction

	task automatic expect_range(input string name, input data_t lo, input data_t hi,
		input data_t act);
		chk_q.push_back('{lo: lo, hi: hi, act: act});
		name_q.push_back(name);
	endtask

	task automatic expect_value(input string name, input data_t exp, input data_t act);
		expect_range(name, exp, exp, act);
	endtask

	// one classic cycle held until ack and dropped in the cycle after it.
	task automatic bus_xfer(input logic wr, input waddr_t a, input data_t d,
		output data_t q);
		int start;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= wr;
		adr <= a;
		dat_w <= d;
		start = cycle;
		@(negedge clk);
		while (!ack && (cycle - start < 20))
			@(negedge clk);
		q = dat_r;
		if (!ack)
		begin
			timeout_count++;
			$display("Timeout: no ack received for address %0d", a);
		end
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic wb_write(input waddr_t a, input data_t d);
		data_t q;
		bus_xfer(1'b1, a, d, q);
		model_write(a, d);
	endtask

	task automatic wb_read(input waddr_t a, output data_t q);
		bus_xfer(1'b0, a, '0, q);
	endtask

	task automatic check_read(input string name, input waddr_t a);
		data_t q;
		wb_read(a, q);
		expect_value(name, model_read(a), q);
	endtask

	task automatic poll_until(input waddr_t a, input data_t mask, input data_t want,
		input int limit, input string what);
		data_t q;
		int start;
		start = cycle;
		wb_read(a, q);
		while (((q & mask) != want) && (cycle - start < limit))
			wb_read(a, q);
		if ((q & mask) != want)
		begin
			timeout_count++;
			$display("Timeout: %s not seen within %0d cycles", what, limit);
		end
	endtask

	task automatic wait_irq(input logic want, input int limit, input string what);
		int start;
		start = cycle;
		@(negedge clk);
		while ((irq != want) && (cycle - start < limit))
			@(negedge clk);
		if (irq != want)
		begin
			timeout_count++;
			$display("Timeout: %s not seen within %0d cycles", what, limit);
		end
	endtask

	always @(negedge clk)
	begin
		while (chk_q.size() > 0)
		begin
			cur = chk_q.pop_front();
			cur_name = name_q.pop_front();
			assert ((cur.act >= cur.lo) && (cur.act <= cur.hi))
			else
			begin
				mismatch_count++;
				if (cur.lo == cur.hi)
					$display("Mismatch %s: expected %h, actual %h",
						cur_name, cur.lo, cur.act);
				else
					$display("Mismatch %s: expected %h to %h, actual %h",
						cur_name, cur.lo, cur.hi, cur.act);
			end
		end
	end

	initial
	begin
		#200000;
		$display("Watchdog expired before the test sequence finished");
		$display("tests failed");
		$finish;
	end

	initial
	begin
		waddr_t un_adr;
		data_t q;
		logic [GPIO_WIDTH-1:0] pin_v;
		int start;
		seed = 65317;
		cycle = 0;
		mismatch_count = 0;
		timeout_count = 0;
		sh_irq_en = '0;
		sh_pending = '0;
		sh_tmr_en = 1'b0;
		sh_counter = '0;
		sh_reload = '0;
		sh_compare = '0;
		sh_dir = '0;
		sh_out = '0;
		sh_pin = '0;
		arst_n <= 1'b0;
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		adr <= '0;
		dat_w <= '0;
		pin_in <= '0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;

		for (int a = 0; a < 32; a++)
			check_read("reset value", waddr_t'(a));
		expect_value("irq after reset", '0, data_t'(irq));
		expect_value("pin_oe after reset", '0, data_t'(pin_oe));

		// with the timer disabled no event disturbs the readback.
		for (int i = 0; i < 8; i++)
		begin
			wb_write(A_RLD, data_t'($random(seed)));
			wb_write(A_CMP, data_t'($random(seed)));
			wb_write(A_DIR, data_t'($random(seed)));
			wb_write(A_OUT, data_t'($random(seed)));
			wb_write(A_IRQ_EN, data_t'($random(seed)));
			un_adr = 5'd11 + waddr_t'({$random(seed)} % 21);
			wb_write(un_adr, data_t'($random(seed)));
			wb_write(5'd2, data_t'($random(seed)));
			wb_write(5'd3, data_t'($random(seed)));
			for (int a = 0; a < 32; a++)
				check_read("register readback", waddr_t'(a));
			expect_value("pin_oe", data_t'(sh_dir), data_t'(pin_oe));
			expect_value("pin_out", data_t'(sh_out), data_t'(pin_out));
		end

		for (int i = 0; i < 4; i++)
		begin
			pin_v = GPIO_WIDTH'($random(seed));
			@(posedge clk);
			pin_in <= pin_v;
			if (pin_v != sh_pin)
				sh_pending[2] = 1'b1;
			sh_pin = pin_v;
			poll_until(A_IN, data_t'({GPIO_WIDTH{1'b1}}), data_t'(pin_v), 10,
				"gpio input value");
			check_read("gpio input", A_IN);
		end

		wb_write(A_CFG, 16'h0000);
		wb_write(A_CMP, 16'h0800);
		wb_write(A_CNT, 16'hFFF0);
		wb_write(A_RLD, 16'h0005);
		wb_write(A_PEND, 16'h0007);
		wb_write(A_IRQ_EN, 16'h0001);
		wb_write(A_CFG, 16'h0001);
		wait_irq(1'b1, 100, "timer overflow irq");
		sh_pending[0] = 1'b1;
		check_read("overflow pending", A_PEND);
		wb_write(A_CFG, 16'h0000);
		wb_read(A_CNT, q);
		expect_range("counter after reload", 16'd5, 16'd104, q);

		wb_write(A_PEND, 16'h0001);
		wait_irq(1'b0, 3, "irq release after clear");
		check_read("pending cleared", A_PEND);
		// source 1 stays masked while its compare event fires.
		wb_write(A_CMP, 16'h0104);
		wb_write(A_CNT, 16'h0100);
		wb_write(A_CFG, 16'h0001);
		poll_until(A_PEND, 16'h0002, 16'h0002, 30, "compare pending");
		sh_pending[1] = 1'b1;
		wb_write(A_CFG, 16'h0000);
		check_read("compare pending", A_PEND);
		expect_value("masked compare irq", '0, data_t'(irq));

		wb_write(A_PEND, 16'h0007);
		wb_write(A_IRQ_EN, 16'h0004);
		@(posedge clk);
		pin_in <= ~sh_pin;
		sh_pin = ~sh_pin;
		sh_pending[2] = 1'b1;
		wait_irq(1'b1, 10, "pin change irq");
		check_read("pin change pending", A_PEND);
		check_read("gpio input after change", A_IN);

		start = cycle;
		@(negedge clk);
		while ((chk_q.size() > 0) && (cycle - start < 10))
			@(negedge clk);
		if (chk_q.size() > 0)
		begin
			timeout_count++;
			$display("Timeout: comparing process left checks unprocessed");
		end

		$display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if ((mismatch_count == 0) && (timeout_count == 0))
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: verilog.f
hdl/io_pkg.sv
hdl/wb_slave_port.sv
hdl/io_timer.sv
hdl/io_gpio.sv
hdl/irq_ctrl.sv
hdl/wb_read_mux.sv
hdl/io_system.sv
bench/tb_clock.sv
bench/io_asserts.sv
bench/io_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module io_tb \
	-Mdir obj_dir

./obj_dir/Vio_tb | tee sim.log

if grep -qx "all tests passed" sim.log; then
	echo "simulation PASS"
else
	echo "simulation FAIL"
	exit 1
fi
